//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - src/mips_pkg.sv
      - src/control.sv
      - src/alu.sv
      - src/reg_file.sv
      - src/pc_unit.sv
      - src/mips_core.sv
  - target: simulation
    files:
      - verif/mips_core_props.sv
      - verif/tb_mips_core.sv

//--- project.f
src/mips_pkg.sv
src/control.sv
src/alu.sv
src/reg_file.sv
src/pc_unit.sv
src/mips_core.sv
verif/mips_core_props.sv
verif/tb_mips_core.sv

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
	input  mips_pkg::ctrl_t   ctrl,
	input  mips_pkg::opcode_t opcode,
	input  mips_pkg::funct_t  funct,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	alu_op_t op;

	// r-type picks by funct, everything else by opcode.
	always_comb begin
		op = alu_add;
		if (ctrl.regdst) begin
			case (funct)
				fn_sub:  op = alu_sub;
				fn_and:  op = alu_and;
				fn_or:   op = alu_or;
				fn_xor:  op = alu_xor;
				fn_slt:  op = alu_slt;
				default: op = alu_add;
			endcase
		end else if (ctrl.isbranch) begin
			op = alu_sub;
		end else if (ctrl.memread || ctrl.memwrite) begin
			op = alu_add;
		end else begin
			case (opcode)
				op_andi: op = alu_and;
				op_ori:  op = alu_or;
				op_xori: op = alu_xor;
				op_slti: op = alu_slt;
				op_lui:  op = alu_lui;
				default: op = alu_add;
			endcase
		end
	end

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {31'd0, $signed(a) < $signed(b)};
			alu_lui: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	// branches compare through the subtract result.
	assign zero = (result == '0);

endmodule

//--- src/control.sv
`timescale 1ns/1ps

module control (
	input  mips_pkg::opcode_t opcode,
	input  mips_pkg::funct_t  funct,
	output mips_pkg::ctrl_t   ctrl
);
	import mips_pkg::*;

	logic funct_ok;

	assign funct_ok = funct inside {fn_add, fn_sub, fn_and, fn_or, fn_xor, fn_slt};

	always_comb begin
		ctrl = '0;
		case (opcode)
			op_rtype: begin
				ctrl.regdst = 1'b1;
				if (funct == fn_jr) begin
					ctrl.isjump  = 1'b1;
					ctrl.jumpdst = 1'b1;
				end else if (funct_ok) begin
					ctrl.regwrite = 1'b1;
				end else begin
					ctrl.illegal = 1'b1;
				end
			end
			op_addi, op_slti, op_lui: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			// logical immediates take a zero-extended operand.
			op_andi, op_ori, op_xori: begin
				ctrl.regwrite     = 1'b1;
				ctrl.alusrc       = 1'b1;
				ctrl.imm_zero_ext = 1'b1;
			end
			op_lw: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			op_sw: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			op_beq, op_bne: begin
				ctrl.isbranch = 1'b1;
			end
			op_j: begin
				ctrl.isjump = 1'b1;
			end
			op_jal: begin
				ctrl.regwrite = 1'b1;
				ctrl.isjump   = 1'b1;
				ctrl.islink   = 1'b1;
			end
			// unknown opcode runs as a no-op.
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

//--- src/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic                clk,
	input  logic                arst_n,
	output mips_pkg::word_t     pc,
	input  mips_pkg::word_t     instr,
	output mips_pkg::dmem_req_t dmem,
	input  mips_pkg::word_t     dmem_rdata,
	output logic                illegal
);
	import mips_pkg::*;

	opcode_t     opcode;
	funct_t      funct;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [15:0] imm16;
	word_t       imm_ext;
	ctrl_t       ctrl;
	word_t       rs_data;
	word_t       rt_data;
	word_t       alu_b;
	word_t       alu_result;
	logic        alu_zero;
	word_t       pc_plus4;
	reg_addr_t   wr_addr;
	word_t       wr_data;

	// instruction fields.
	assign opcode = opcode_t'(instr[31:26]);
	assign funct  = funct_t'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign imm16  = instr[15:0];

	assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	control u_control (
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrl)
	);

	reg_file u_reg_file (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (rs),
		.rt_addr (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.we      (ctrl.regwrite),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	assign alu_b = ctrl.alusrc ? imm_ext : rt_data;

	alu u_alu (
		.ctrl   (ctrl),
		.opcode (opcode),
		.funct  (funct),
		.a      (rs_data),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// opcode bit 0 tells bne from beq.
	pc_unit u_pc_unit (
		.clk        (clk),
		.arst_n     (arst_n),
		.ctrl       (ctrl),
		.is_bne     (instr[26]),
		.zero       (alu_zero),
		.imm        (imm_ext),
		.jump_index (instr[25:0]),
		.rs_data    (rs_data),
		.pc         (pc),
		.pc_plus4   (pc_plus4)
	);

	// jal links through register 31.
	assign wr_addr = ctrl.islink ? link_reg : (ctrl.regdst ? rd : rt);
	assign wr_data = ctrl.islink ? pc_plus4 : (ctrl.memtoreg ? dmem_rdata : alu_result);

	// no memory strobes while reset is held.
	assign dmem.addr  = alu_result;
	assign dmem.wdata = rt_data;
	assign dmem.re    = ctrl.memread && arst_n;
	assign dmem.we    = ctrl.memwrite && arst_n;

	assign illegal = ctrl.illegal;

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// primary opcode, instr[31:26].
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_xori  = 6'h0e,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// r-type function field, instr[5:0].
	typedef enum logic [5:0] {
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_xor = 6'h26,
		fn_slt = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4,
		alu_slt = 4'd5,
		alu_lui = 4'd6
	} alu_op_t;

	// decoded control bits for one instruction.
	typedef struct packed {
		logic regwrite;
		logic memtoreg;
		logic memread;
		logic memwrite;
		logic isbranch;
		logic regdst;
		logic alusrc;
		logic isjump;
		logic islink;
		logic jumpdst;
		logic imm_zero_ext;
		logic illegal;
	} ctrl_t;

	// data port request, answered in the same cycle.
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  re;
		logic  we;
	} dmem_req_t;

	// jal return address goes here.
	localparam reg_addr_t link_reg = 5'd31;
	localparam word_t     reset_pc = 32'h0000_0000;

endpackage

//--- src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
	input  logic            clk,
	input  logic            arst_n,
	input  mips_pkg::ctrl_t ctrl,
	input  logic            is_bne,
	input  logic            zero,
	input  mips_pkg::word_t imm,
	input  logic [25:0]     jump_index,
	input  mips_pkg::word_t rs_data,
	output mips_pkg::word_t pc,
	output mips_pkg::word_t pc_plus4
);
	import mips_pkg::*;

	word_t pc_next;
	logic  taken;

	assign pc_plus4 = pc + 32'd4;

	// bne wants the inverse of the compare.
	assign taken = ctrl.isbranch && (zero ^ is_bne);

	always_comb begin
		if (ctrl.jumpdst) begin
			pc_next = rs_data;
		end else if (ctrl.isjump) begin
			pc_next = {pc_plus4[31:28], jump_index, 2'b00};
		end else if (taken) begin
			pc_next = pc_plus4 + {imm[29:0], 2'b00};
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                arst_n,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	output mips_pkg::word_t     rs_data,
	output mips_pkg::word_t     rt_data,
	input  logic                we,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data
);
	import mips_pkg::*;

	// register 0 has no storage.
	word_t regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- verif/mips_core_props.sv
`timescale 1ns/1ps

module mips_core_props (
	input logic                clk,
	input logic                arst_n,
	input mips_pkg::word_t     pc,
	input mips_pkg::dmem_req_t dmem,
	input logic                illegal
);
	import mips_pkg::*;

	int unsigned fail_count = 0;

	// pc held at its reset value and no memory strobe while reset is low.
	reset_state: assert property (@(posedge clk)
		!arst_n |-> (pc == reset_pc) && !dmem.re && !dmem.we)
	else begin
		$error("pc or a memory strobe is wrong while reset is held");
		fail_count++;
	end

	// the first cycle after reset still fetches from reset_pc.
	reset_exit: assert property (@(posedge clk)
		!arst_n |=> pc == reset_pc)
	else begin
		$error("pc left its reset value before the first instruction ran");
		fail_count++;
	end

	illegal_no_store: assert property (@(posedge clk) disable iff (!arst_n)
		illegal |-> !dmem.we)
	else begin
		$error("a store was issued by an illegal instruction");
		fail_count++;
	end

	illegal_advance: assert property (@(posedge clk) disable iff (!arst_n)
		illegal |=> pc == $past(pc) + 32'd4)
	else begin
		$error("pc did not advance by 4 after an illegal instruction");
		fail_count++;
	end

endmodule

bind mips_core mips_core_props u_mips_core_props (.*);

//--- verif/tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core;
	import mips_pkg::*;

	logic      clk;
	logic      arst_n;
	word_t     pc;
	word_t     instr;
	dmem_req_t dmem;
	word_t     dmem_rdata;
	logic      illegal;

	word_t imem [256];
	word_t dram [256];
	string label [256];
	int    wp;
	int    slot;
	word_t rng;
	word_t end_pc;
	logic  model_on;

	// reference model state.
	word_t m_pc;
	word_t m_regs [32];
	word_t m_mem [256];

	mips_core u_mips_core (
		.clk        (clk),
		.arst_n     (arst_n),
		.pc         (pc),
		.instr      (instr),
		.dmem       (dmem),
		.dmem_rdata (dmem_rdata),
		.illegal    (illegal)
	);

	always #2 clk = ~clk;

	assign instr      = imem[pc[9:2]];
	assign dmem_rdata = dram[dmem.addr[9:2]];

	always @(posedge clk) begin
		if (dmem.we) begin
			dram[dmem.addr[9:2]] <= dmem.wdata;
		end
	end

	function automatic word_t xorshift32(input word_t s);
		word_t x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [15:0] rand16();
		rng = xorshift32(rng);
		return rng[15:0];
	endfunction

	function automatic word_t r_instr(input logic [5:0] fn, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_instr(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_instr(input logic [5:0] op, input logic [25:0] idx);
		return {op, idx};
	endfunction

	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input string what, input word_t exp,
			input word_t act);
		assert (act === exp) else begin
			$display("Mismatch %s %s: expected %h actual %h", name, what, exp, act);
			fail_run();
		end
	endtask

	task automatic emit(input word_t ins, input string name);
		imem[wp]  = ins;
		label[wp] = name;
		wp++;
	endtask

	// each store goes to a fresh word at slot*4.
	task automatic store(input reg_addr_t r, input string name);
		emit(i_instr(op_sw, r, 5'd0, 16'(slot * 4)), name);
		slot++;
	endtask

	task automatic load_rand(input reg_addr_t r, input string name);
		emit(i_instr(op_lui, r, 5'd0, rand16()), name);
		emit(i_instr(op_ori, r, r, rand16()), name);
	endtask

	task automatic build_program();
		int k;
		int ret_wp;
		// a store at reset_pc gives reset a strobe to hold off.
		store(5'd0, "reset_strobe");
		for (k = 0; k < 3; k++) begin
			load_rand(5'd1, "imm_alu");
			emit(i_instr(op_addi, 5'd2, 5'd1, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
			emit(i_instr(op_lui, 5'd2, 5'd0, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
			emit(i_instr(op_ori, 5'd2, 5'd1, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
			emit(i_instr(op_andi, 5'd2, 5'd1, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
			emit(i_instr(op_xori, 5'd2, 5'd1, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
			emit(i_instr(op_slti, 5'd2, 5'd1, rand16()), "imm_alu");
			store(5'd2, "imm_alu");
		end
		for (k = 0; k < 3; k++) begin
			load_rand(5'd3, "reg_alu");
			load_rand(5'd4, "reg_alu");
			emit(r_instr(fn_add, 5'd5, 5'd3, 5'd4), "reg_alu");
			store(5'd5, "reg_alu");
			emit(r_instr(fn_sub, 5'd5, 5'd3, 5'd4), "reg_alu");
			store(5'd5, "reg_alu");
			emit(r_instr(fn_and, 5'd5, 5'd3, 5'd4), "reg_alu");
			store(5'd5, "reg_alu");
			emit(r_instr(fn_or, 5'd5, 5'd3, 5'd4), "reg_alu");
			store(5'd5, "reg_alu");
			emit(r_instr(fn_xor, 5'd5, 5'd3, 5'd4), "reg_alu");
			store(5'd5, "reg_alu");
			emit(r_instr(fn_slt, 5'd5, 5'd4, 5'd3), "reg_alu");
			store(5'd5, "reg_alu");
		end
		for (k = 0; k < 2; k++) begin
			store(5'd3 + 5'(k), "load_store");
			emit(i_instr(op_lw, 5'd6, 5'd0, 16'((slot - 1) * 4)), "load_store");
			store(5'd6, "load_store");
		end
		// each taken branch skips one addi.
		emit(i_instr(op_addi, 5'd7, 5'd0, 16'h0001), "branch");
		emit(i_instr(op_beq, 5'd3, 5'd3, 16'h0001), "branch");
		emit(i_instr(op_addi, 5'd7, 5'd7, 16'h0002), "branch");
		emit(i_instr(op_beq, 5'd4, 5'd3, 16'h0001), "branch");
		emit(i_instr(op_addi, 5'd7, 5'd7, 16'h0004), "branch");
		emit(i_instr(op_bne, 5'd4, 5'd3, 16'h0001), "branch");
		emit(i_instr(op_addi, 5'd7, 5'd7, 16'h0008), "branch");
		emit(i_instr(op_bne, 5'd3, 5'd3, 16'h0001), "branch");
		emit(i_instr(op_addi, 5'd7, 5'd7, 16'h0010), "branch");
		store(5'd7, "branch");
		emit(j_instr(op_j, 26'(wp + 2)), "jump");
		emit(i_instr(op_addi, 5'd7, 5'd7, 16'h0020), "jump");
		store(5'd7, "jump");
		// subroutine sits far above the main program.
		emit(j_instr(op_jal, 26'd200), "jal_jr");
		ret_wp = wp;
		wp = 200;
		store(5'd31, "jal_jr");
		emit(r_instr(fn_jr, 5'd0, 5'd31, 5'd0), "jal_jr");
		wp = ret_wp;
		emit({6'h3f, 10'(rand16()), rand16()}, "illegal");
		emit(r_instr(6'h01, 5'd8, 5'd3, 5'd4), "illegal");
		store(5'd8, "illegal");
		end_pc = word_t'(wp * 4);
		emit(j_instr(op_j, 26'(wp)), "end");
	endtask

	task automatic set_reg(input reg_addr_t r, input word_t v);
		if (r != 5'd0) begin
			m_regs[r] = v;
		end
	endtask

	task automatic model_step();
		word_t      ins;
		word_t      a;
		word_t      b;
		word_t      sx;
		word_t      zx;
		word_t      addr;
		word_t      npc;
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic       legal;
		string      name;
		ins  = imem[m_pc[9:2]];
		name = label[m_pc[9:2]];
		check_word(name, "pc", m_pc, pc);
		op    = ins[31:26];
		fn    = ins[5:0];
		rs    = ins[25:21];
		rt    = ins[20:16];
		rd    = ins[15:11];
		a     = m_regs[rs];
		b     = m_regs[rt];
		sx    = {{16{ins[15]}}, ins[15:0]};
		zx    = {16'h0000, ins[15:0]};
		addr  = a + sx;
		npc   = m_pc + 32'd4;
		legal = 1'b1;
		check_word(name, "store strobe", {31'd0, op == op_sw}, {31'd0, dmem.we});
		check_word(name, "load strobe", {31'd0, op == op_lw}, {31'd0, dmem.re});
		case (op)
			op_rtype: begin
				case (fn)
					fn_add:  set_reg(rd, a + b);
					fn_sub:  set_reg(rd, a - b);
					fn_and:  set_reg(rd, a & b);
					fn_or:   set_reg(rd, a | b);
					fn_xor:  set_reg(rd, a ^ b);
					fn_slt:  set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					fn_jr:   npc = a;
					default: legal = 1'b0;
				endcase
			end
			op_addi: set_reg(rt, a + sx);
			op_slti: set_reg(rt, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
			op_andi: set_reg(rt, a & zx);
			op_ori:  set_reg(rt, a | zx);
			op_xori: set_reg(rt, a ^ zx);
			op_lui:  set_reg(rt, {ins[15:0], 16'h0000});
			op_lw:   set_reg(rt, m_mem[addr[9:2]]);
			op_sw: begin
				check_word(name, "store address", addr, dmem.addr);
				check_word(name, "store data", b, dmem.wdata);
				m_mem[addr[9:2]] = b;
			end
			op_beq: begin
				if (a == b) begin
					npc = npc + (sx << 2);
				end
			end
			op_bne: begin
				if (a != b) begin
					npc = npc + (sx << 2);
				end
			end
			op_j: npc = {npc[31:28], ins[25:0], 2'b00};
			op_jal: begin
				set_reg(5'd31, npc);
				npc = {npc[31:28], ins[25:0], 2'b00};
			end
			default: legal = 1'b0;
		endcase
		check_word(name, "illegal flag", {31'd0, !legal}, {31'd0, illegal});
		m_pc = npc;
	endtask

	always @(posedge clk) begin
		if (model_on) begin
			model_step();
		end
	end

	always @(negedge clk) begin
		if (u_mips_core.u_mips_core_props.fail_count != 0) begin
			$display("a bound property of the core failed");
			fail_run();
		end
	end

	initial begin
		int    cycles;
		logic  reached;
		word_t first_ins;
		clk      = 1'b0;
		arst_n   = 1'b1;
		model_on = 1'b0;
		rng      = 32'h1cd8;
		wp       = 0;
		slot     = 0;
		m_pc     = reset_pc;
		for (int i = 0; i < 256; i++) begin
			imem[i]  = j_instr(op_j, 26'(i));
			label[i] = "fill";
			dram[i]  = 32'hd0d0_0000 | word_t'(i << 2);
			m_mem[i] = dram[i];
		end
		for (int i = 0; i < 32; i++) begin
			m_regs[i] = '0;
		end
		build_program();
		first_ins = imem[0];
		@(negedge clk);
		arst_n = 1'b0;
		// a load sits at reset_pc for the first half of reset.
		imem[0] = i_instr(op_lw, 5'd6, 5'd0, 16'h0000);
		repeat (2) @(negedge clk);
		imem[0] = first_ins;
		repeat (2) @(negedge clk);
		arst_n   = 1'b1;
		model_on = 1'b1;
		reached  = 1'b0;
		for (cycles = 0; cycles < 1000 && !reached; cycles++) begin
			@(negedge clk);
			reached = (pc == end_pc);
		end
		if (!reached) begin
			$display("timed out waiting for the core to reach the final self-jump");
			fail_run();
		end else begin
			repeat (3) @(negedge clk);
			if (u_mips_core.u_mips_core_props.fail_count == 0) begin
				$display("TESTS PASSED");
				$finish;
			end else begin
				$display("a bound property of the core failed");
				fail_run();
			end
		end
	end

endmodule
